// ==== logic/execParams.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Register file and datapath width
`define DATA_WIDTH 16

// Architectural registers, indexed by three bits
`define REG_COUNT 8

// Decoded operations parked between decode and execute
`define BUFFER_DEPTH 4

`endif

// ==== logic/isaPkg.sv ====
`include "execParams.svh"

package isaPkg;

	typedef logic [$clog2(`REG_COUNT)-1:0] regIndexT;

	typedef enum logic [3:0] {
		ADI = 4'b0000,
		ADDFAM = 4'b0001,
		NANDFAM = 4'b0010,
		LLI = 4'b0011
	} opcodeT;

	// Bits 1..0 of an add or nand word
	typedef enum logic [1:0] {
		modeAlways = 2'b00,
		modeIfZero = 2'b01,
		modeIfCarry = 2'b10,
		modeWithCarry = 2'b11
	} modeT;

	typedef struct packed {
		opcodeT opcode;
		regIndexT regA;
		regIndexT regB;
		regIndexT regC;
		logic complement; // Use ~B
		modeT mode;
	} rTypeT;

	typedef struct packed {
		opcodeT opcode;
		regIndexT regA;
		regIndexT regB;
		logic [5:0] imm6;
	} iTypeT;

	typedef struct packed {
		opcodeT opcode;
		regIndexT regA;
		logic [8:0] imm9;
	} jTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
		jTypeT jType;
	} instrWord;

	function automatic logic [`DATA_WIDTH-1:0] signExtendImm6(input logic [5:0] imm);
		return {{(`DATA_WIDTH - 6){imm[5]}}, imm};
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] zeroExtendImm9(input logic [8:0] imm);
		return {{(`DATA_WIDTH - 9){1'b0}}, imm};
	endfunction

endpackage

// ==== logic/pipePkg.sv ====
`include "execParams.svh"

package pipePkg;

	typedef enum logic [2:0] {
		opNop,
		opAdd,
		opNand,
		opAddImm,
		opLoadImm
	} opClassT;

	typedef struct packed {
		opClassT opClass;
		isaPkg::modeT mode;
		logic complement;
		isaPkg::regIndexT srcA;
		isaPkg::regIndexT srcB;
		isaPkg::regIndexT dest;
		logic usesB; // Else B comes from imm
		logic [`DATA_WIDTH-1:0] imm;
		logic writesCarry;
		logic writesZero;
	} decodedOp;

	// Flags are the values after the instruction
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] value;
		isaPkg::regIndexT dest;
		logic written;
		logic carry;
		logic zero;
	} resultReport;

endpackage

// ==== logic/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
	input logic clock,
	input logic reset,
	input logic instrReq,
	input isaPkg::instrWord instr,
	output logic instrAck,
	input logic full,
	output logic push,
	output pipePkg::decodedOp pushOp
);
	import isaPkg::*;
	import pipePkg::*;

	logic acceptNow;
	decodedOp decoded;

	// New request, idle phase, room in buffer
	assign acceptNow = instrReq && !instrAck && !full;

	always_comb
	begin
		decoded = '0;
		decoded.opClass = opNop;
		decoded.mode = modeAlways;
		case (instr.rType.opcode)
			ADDFAM:
			begin
				decoded.opClass = opAdd;
				decoded.mode = instr.rType.mode;
				decoded.complement = instr.rType.complement;
				decoded.srcA = instr.rType.regA;
				decoded.srcB = instr.rType.regB;
				decoded.dest = instr.rType.regC;
				decoded.usesB = 1'b1;
				decoded.writesCarry = 1'b1;
				decoded.writesZero = 1'b1;
			end
			NANDFAM:
			begin
				if (instr.rType.mode != modeWithCarry) // Mode 11 has no nand form
				begin
					decoded.opClass = opNand;
					decoded.mode = instr.rType.mode;
					decoded.complement = instr.rType.complement;
					decoded.srcA = instr.rType.regA;
					decoded.srcB = instr.rType.regB;
					decoded.dest = instr.rType.regC;
					decoded.usesB = 1'b1;
					decoded.writesZero = 1'b1;
				end
			end
			ADI:
			begin
				decoded.opClass = opAddImm;
				decoded.srcA = instr.iType.regA;
				decoded.srcB = instr.iType.regB;
				decoded.dest = instr.iType.regB;
				decoded.imm = signExtendImm6(instr.iType.imm6);
				decoded.writesCarry = 1'b1;
				decoded.writesZero = 1'b1;
			end
			LLI:
			begin
				decoded.opClass = opLoadImm;
				decoded.srcA = instr.jType.regA;
				decoded.dest = instr.jType.regA;
				decoded.imm = zeroExtendImm9(instr.jType.imm9);
			end
			default:
			begin
				decoded.opClass = opNop; // Still reported, never writes
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			instrAck <= 1'b0;
			push <= 1'b0;
		end
		else
		begin
			push <= acceptNow; // One push per request
			if (acceptNow)
				instrAck <= 1'b1;
			else if (instrAck && !instrReq)
				instrAck <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (acceptNow)
			pushOp <= decoded;
	end

	assert property (@(posedge clock) disable iff (reset) $rose(instrAck) |-> $past(instrReq))
	else $error("instrAck rose without a pending instrReq");

endmodule

// ==== logic/opBuffer.sv ====
`timescale 1ns/10ps
`include "execParams.svh"

module opBuffer (
	input logic clock,
	input logic reset,
	input logic push,
	input pipePkg::decodedOp pushOp,
	output logic full,
	input logic pop,
	output pipePkg::decodedOp headOp,
	output logic empty
);
	import pipePkg::*;

	localparam int PTR_WIDTH = $clog2(`BUFFER_DEPTH);

	decodedOp entries [`BUFFER_DEPTH];
	logic [PTR_WIDTH-1:0] writePtr;
	logic [PTR_WIDTH-1:0] readPtr;
	logic [PTR_WIDTH:0] count;

	assign full = (count == `BUFFER_DEPTH);
	assign empty = (count == 0);
	assign headOp = entries[readPtr];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			writePtr <= '0;
			readPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				writePtr <= writePtr + 1'b1; // Wraps at depth
			if (pop)
				readPtr <= readPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (push)
			entries[writePtr] <= pushOp;
	end

	assert property (@(posedge clock) disable iff (reset) push |-> !full)
	else $error("push into a full buffer");

	assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
	else $error("pop from an empty buffer");

endmodule

// ==== logic/aluExecute.sv ====
`timescale 1ns/10ps
`include "execParams.svh"

module aluExecute (
	input logic clock,
	input logic reset,
	input pipePkg::decodedOp headOp,
	input logic empty,
	output logic pop,
	output logic reportReq,
	input logic reportAck,
	output pipePkg::resultReport report
);
	import isaPkg::*;
	import pipePkg::*;

	logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
	logic carryFlag;
	logic zeroFlag;

	logic rdValid;
	decodedOp rdOp;
	logic exValid;
	decodedOp exOp;
	logic [`DATA_WIDTH-1:0] exA;
	logic [`DATA_WIDTH-1:0] exB;
	logic wbValid;
	resultReport wbReport;

	logic wbLoad;
	logic exReady;
	logic rdReady;
	logic wbWrites;
	logic [`DATA_WIDTH-1:0] readA;
	logic [`DATA_WIDTH-1:0] readB;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] fwdB;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] bEff;
	logic [`DATA_WIDTH-1:0] sum;
	logic [`DATA_WIDTH-1:0] aluResult;
	logic carryIn;
	logic carryOut;
	logic conditionMet;
	logic execEnable;
	resultReport execResult;

	// Writeback holds until ack, the rest of the pipe stalls behind it
	assign wbLoad = exValid && !wbValid && !reportAck;
	assign exReady = !exValid || wbLoad;
	assign rdReady = !rdValid || exReady;
	assign pop = !empty && rdReady;
	assign reportReq = wbValid;
	assign report = wbReport;

	assign wbWrites = wbValid && wbReport.written; // Skipped ops never forward

	// Read stage, bypass the write landing this cycle
	assign readA = (wbWrites && wbReport.dest == rdOp.srcA) ? wbReport.value
		: regFile[rdOp.srcA];
	assign readB = (wbWrites && wbReport.dest == rdOp.srcB) ? wbReport.value
		: regFile[rdOp.srcB];

	// Execute stage, forward from writeback
	assign opA = (wbWrites && wbReport.dest == exOp.srcA) ? wbReport.value : exA;
	assign fwdB = (wbWrites && wbReport.dest == exOp.srcB) ? wbReport.value : exB;
	assign opB = exOp.usesB ? fwdB : exOp.imm;
	assign bEff = exOp.complement ? ~opB : opB;
	assign carryIn = (exOp.opClass == opAdd && exOp.mode == modeWithCarry) ? carryFlag : 1'b0;

	always_comb
	begin
		{carryOut, sum} = {1'b0, opA} + {1'b0, bEff} + {{`DATA_WIDTH{1'b0}}, carryIn};
		case (exOp.opClass)
			opAdd, opAddImm: aluResult = sum;
			opNand: aluResult = ~(opA & bEff);
			opLoadImm: aluResult = exOp.imm;
			default: aluResult = '0;
		endcase
	end

	always_comb
	begin
		case (exOp.mode)
			modeIfCarry: conditionMet = carryFlag;
			modeIfZero: conditionMet = zeroFlag;
			default: conditionMet = 1'b1; // Plain and with-carry forms
		endcase
	end

	assign execEnable = (exOp.opClass != opNop) && conditionMet;

	always_comb
	begin
		execResult.value = execEnable ? aluResult : '0;
		execResult.dest = exOp.dest;
		execResult.written = execEnable;
		execResult.carry = (execEnable && exOp.writesCarry) ? carryOut : carryFlag;
		execResult.zero = (execEnable && exOp.writesZero) ? (aluResult == '0) : zeroFlag;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rdValid <= 1'b0;
			exValid <= 1'b0;
			wbValid <= 1'b0;
			carryFlag <= 1'b0;
			zeroFlag <= 1'b0;
		end
		else
		begin
			if (rdReady)
				rdValid <= pop;
			if (exReady)
				exValid <= rdValid;
			if (wbLoad)
			begin
				wbValid <= 1'b1;
				carryFlag <= execResult.carry;
				zeroFlag <= execResult.zero;
			end
			else if (wbValid && reportAck)
				wbValid <= 1'b0; // Retire on ack
		end
	end

	always_ff @(posedge clock)
	begin
		if (pop)
			rdOp <= headOp;
		if (exReady)
		begin
			exOp <= rdOp;
			exA <= readA;
			exB <= readB;
		end
		else
		begin
			exA <= opA; // Keep forwarded values once writeback retires
			exB <= fwdB;
		end
		if (wbLoad)
			wbReport <= execResult;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regFile[i] <= '0;
		end
		else if (wbWrites)
			regFile[wbReport.dest] <= wbReport.value;
	end

	assert property (@(posedge clock) disable iff (reset)
		reportReq && !reportAck |=> $stable(report))
	else $error("report changed while waiting for reportAck");

endmodule

// ==== logic/execCore.sv ====
`timescale 1ns/10ps

module execCore (
	input logic clock,
	input logic reset,
	input logic instrReq,
	input isaPkg::instrWord instr,
	output logic instrAck,
	output logic reportReq,
	input logic reportAck,
	output pipePkg::resultReport report
);
	import pipePkg::*;

	logic push;
	logic full;
	logic pop;
	logic empty;
	decodedOp pushOp;
	decodedOp headOp;

	instrDecoder decoder (
		.clock(clock),
		.reset(reset),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.full(full),
		.push(push),
		.pushOp(pushOp)
	);

	opBuffer buffer (
		.clock(clock),
		.reset(reset),
		.push(push),
		.pushOp(pushOp),
		.full(full),
		.pop(pop),
		.headOp(headOp),
		.empty(empty)
	);

	aluExecute execute (
		.clock(clock),
		.reset(reset),
		.headOp(headOp),
		.empty(empty),
		.pop(pop),
		.reportReq(reportReq),
		.reportAck(reportAck),
		.report(report)
	);

endmodule

// ==== testbench/execCoreTb.sv ====
`timescale 1ns/10ps
`include "execParams.svh"

module execCoreTb;
	import isaPkg::*;
	import pipePkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic clock;
	logic reset;
	logic instrReq;
	instrWord instr;
	logic instrAck;
	logic reportReq;
	logic reportAck;
	resultReport report;

	string testNames[$];
	logic [`DATA_WIDTH-1:0] instrWords[$];
	resultReport expected[$];

	int errorCount;
	int checkCount;
	int timeoutCount;
	integer seed;

	execCore DUT (
		.clock(clock),
		.reset(reset),
		.instrReq(instrReq),
		.instr(instr),
		.instrAck(instrAck),
		.reportReq(reportReq),
		.reportAck(reportAck),
		.report(report)
	);

	always #20 clock = ~clock;

	task automatic loadPatterns();
		int fd;
		int fields;
		string line;
		string name;
		logic [`DATA_WIDTH-1:0] word;
		logic [`DATA_WIDTH-1:0] value;
		logic [2:0] dest;
		logic written;
		logic carry;
		logic zero;
		resultReport entry;
		fd = $fopen("testbench/execPatterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open testbench/execPatterns.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line[0] == "#")
				continue; // Blank or column notes
			fields = $sscanf(line, "%s %h %h %d %d %d %d", name, word, value, dest, written,
				carry, zero);
			if (fields != 7)
			begin
				$display("Malformed pattern line: %s", line);
				errorCount++;
				continue;
			end
			entry.value = value;
			entry.dest = dest;
			entry.written = written;
			entry.carry = carry;
			entry.zero = zero;
			testNames.push_back(name);
			instrWords.push_back(word);
			expected.push_back(entry);
		end
		$fclose(fd);
		if (testNames.size() == 0)
		begin
			$display("Pattern file holds no instructions");
			errorCount++;
		end
	endtask

	task automatic checkField(input string testName, input string field,
		input logic [31:0] expectedVal, input logic [31:0] actualVal);
		checkCount++;
		assert (actualVal === expectedVal)
		else
		begin
			errorCount++;
			$display("CHECK FAILED %s %s: expected %0h, actual %0h", testName, field,
				expectedVal, actualVal);
		end
	endtask

	task automatic compareReport(input string testName, input resultReport exp);
		checkField(testName, "value", 32'(exp.value), 32'(report.value));
		checkField(testName, "dest", 32'(exp.dest), 32'(report.dest));
		checkField(testName, "written", 32'(exp.written), 32'(report.written));
		checkField(testName, "carry", 32'(exp.carry), 32'(report.carry));
		checkField(testName, "zero", 32'(exp.zero), 32'(report.zero));
	endtask

	task automatic driveInstructions();
		int waited;
		for (int i = 0; i < instrWords.size(); i++)
		begin
			instr = instrWords[i];
			instrReq = 1'b1;
			waited = 0;
			while (instrAck !== 1'b1 && waited < TIMEOUT_CYCLES)
			begin
				@(posedge clock);
				#2;
				waited++;
			end
			if (instrAck !== 1'b1)
			begin
				$display("Timeout: instrAck never rose for %s", testNames[i]);
				timeoutCount++;
				instrReq = 1'b0;
				break;
			end
			instrReq = 1'b0;
			waited = 0;
			while (instrAck !== 1'b0 && waited < TIMEOUT_CYCLES)
			begin
				@(posedge clock);
				#2;
				waited++;
			end
			if (instrAck !== 1'b0)
			begin
				$display("Timeout: instrAck stuck high after %s", testNames[i]);
				timeoutCount++;
				break;
			end
		end
	endtask

	task automatic collectReports();
		int waited;
		int delayCycles;
		for (int i = 0; i < expected.size(); i++)
		begin
			waited = 0;
			while (reportReq !== 1'b1 && waited < TIMEOUT_CYCLES)
			begin
				@(posedge clock);
				#2;
				waited++;
			end
			if (reportReq !== 1'b1)
			begin
				$display("Timeout: no report arrived for %s", testNames[i]);
				timeoutCount++;
				return;
			end
			compareReport(testNames[i], expected[i]);
			delayCycles = $unsigned($random(seed)) % 6; // Random back-pressure
			repeat (delayCycles)
			begin
				@(posedge clock);
				#2;
			end
			reportAck = 1'b1;
			waited = 0;
			while (reportReq !== 1'b0 && waited < TIMEOUT_CYCLES)
			begin
				@(posedge clock);
				#2;
				waited++;
			end
			reportAck = 1'b0;
			if (reportReq !== 1'b0)
			begin
				$display("Timeout: reportReq stuck high after ack for %s", testNames[i]);
				timeoutCount++;
				return;
			end
		end
		// Nothing may follow the last expected report
		repeat (20)
		begin
			@(posedge clock);
			#2;
			checkCount++;
			assert (reportReq === 1'b0)
			else
			begin
				errorCount++;
				$display("An extra report arrived after the last expected one");
			end
		end
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		reportAck = 1'b0;
		errorCount = 0;
		checkCount = 0;
		timeoutCount = 0;
		seed = 32'he947_9473;
		loadPatterns();
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;
		checkCount++;
		assert (instrAck === 1'b0 && reportReq === 1'b0)
		else
		begin
			errorCount++;
			$display("instrAck or reportReq is high right after reset");
		end
		fork
			driveInstructions();
			collectReports();
		join
		$display("Summary: %0d checks, %0d errors, %0d timeouts", checkCount, errorCount,
			timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== testbench/execPatterns.txt ====
# name instr(hex) value(hex) dest written carry zero
# value, dest and flags are the expected report after each instruction, in order
lliR0 31FF 01FF 0 1 0 0
lliR1 3201 0001 1 1 0 0
lliR2 3500 0100 2 1 0 0
lliR3 36AA 00AA 3 1 0 0
lliR4 3855 0055 4 1 0 0
lliR5 3AF0 00F0 5 1 0 0
lliR6 3C0F 000F 6 1 0 0
lliR7 3E00 0000 7 1 0 0
adaPlain 1738 00FF 7 1 0 0
adcSkipped 1052 0000 2 0 0 0
adzSkipped 1051 0000 2 0 0 0
acaZeroCarry 15EC 0000 5 1 1 1
adzTaken 1731 00FF 6 1 0 0
acaCarry 106C 01FD 5 1 1 0
awcCarryIn 1253 0003 2 1 0 0
accSkipped 105E 0000 3 0 0 0
acwNoCarryIn 1077 01FD 6 1 1 0
adcTaken 12BA 0004 7 1 0 0
aczSkipped 1065 0000 4 0 0 0
adiWrapZero 03FF 0000 7 1 1 1
adiNegative 0120 01DF 4 1 1 0
nduForward 2728 FF75 5 1 1 0
ndzSkipped 26F1 0000 6 0 1 0
ncuOnes 2B74 FFFF 6 1 1 0
ncuZero 2DDC 0000 3 1 1 1
nczTaken 2315 FFFF 2 1 1 0
nczSkipped 203D 0000 7 0 1 0
nccTaken 2066 FE01 4 1 1 0
lliChain 3610 0010 3 1 1 0
adaNextUse 16D8 0020 3 1 0 0
adaFwdOne 1668 0021 5 1 0 0
adaFwdTwo 16F0 0040 6 1 0 0
adcSkipDep 1B5A 0000 3 0 0 0
adaNoSkipFwd 1678 0021 7 1 0 0
unknownOp 4ABC 0000 0 0 0 0
nandMode3 2DDF 0000 0 0 0 0

// ==== flist.f ====
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/instrDecoder.sv
logic/opBuffer.sv
logic/aluExecute.sv
logic/execCore.sv
testbench/execCoreTb.sv

// ==== Makefile ====
TOP = execCoreTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o simExec
	./obj_dir/simExec > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
